//--- rtl/fixed_range_reduction.sv
// Leading-one normalization of an unsigned Q4.4 sample.
// The highest set bit is moved to the top, giving x in [1, 2) as Q1.7,
// and its position is reported so the reciprocal can be scaled back.

`timescale 1ns/100ps
`default_nettype none

module fixed_range_reduction (
  input  softermax_recip_pkg::in_data_t data_in,
  output softermax_recip_pkg::reduced_t data_out,
  output softermax_recip_pkg::msb_idx_t msb_index,
  output logic                          not_found
);

  softermax_recip_pkg::msb_idx_t lshift;

  // Last match wins, so the highest set bit is kept
  always_comb begin
    msb_index = '0;
    not_found = 1'b1;
    for (int i = 0; i < softermax_recip_pkg::IN_WIDTH; i++) begin
      if (data_in[i]) begin
        msb_index = softermax_recip_pkg::msb_idx_t'(i);
        not_found = 1'b0;
      end
    end
  end

  // Distance from the leading one to the top bit
  assign lshift = softermax_recip_pkg::msb_idx_t'(softermax_recip_pkg::IN_WIDTH - 1)
                  - msb_index;

  assign data_out = data_in << lshift;

endmodule

`default_nettype wire

//--- rtl/fixed_unsigned_cast.sv
// Floor cast of the scaled reciprocal down to unsigned Q3.5.
// Low fraction bits are dropped and any integer bit beyond the
// output range saturates the result to all ones.

`timescale 1ns/100ps
`default_nettype none

module fixed_unsigned_cast (
  input  softermax_recip_pkg::recip_t    data_in,
  output softermax_recip_pkg::out_data_t data_out
);

  localparam int DROP_BITS = softermax_recip_pkg::RECIP_FRAC_WIDTH
                             - softermax_recip_pkg::OUT_FRAC_WIDTH;
  localparam int KEEP_MSB  = DROP_BITS + softermax_recip_pkg::OUT_WIDTH - 1;
  localparam int TOP_BIT   = softermax_recip_pkg::RECIP_WIDTH - 1;

  logic overflow;

  // Anything above bit 2 of the integer part does not fit in Q3.5
  assign overflow = |data_in[TOP_BIT:KEEP_MSB+1];

  // Truncation of a positive value is a floor
  assign data_out = overflow ? '1 : data_in[KEEP_MSB:DROP_BITS];

endmodule

`default_nettype wire

//--- rtl/lpw_coeff_rom.sv
// Slope and intercept tables for 1/x over [1, 2).
// Each of the ENTRIES equal segments uses its chord, so the line never
// falls below the curve. Tables are constants built at elaboration and
// read combinationally through two independent ports.

`timescale 1ns/100ps
`default_nettype none

module lpw_coeff_rom #(
  parameter  int ENTRIES   = 8,
  localparam int SEG_WIDTH = $clog2(ENTRIES)
) (
  input  logic [SEG_WIDTH-1:0]            seg_slope,
  output softermax_recip_pkg::slope_t     slope,
  input  logic [SEG_WIDTH-1:0]            seg_intercept,
  output softermax_recip_pkg::intercept_t intercept
);

  localparam int SLOPE_SCALE     = 1 << softermax_recip_pkg::SLOPE_FRAC_WIDTH;
  localparam int INTERCEPT_SCALE = 1 << softermax_recip_pkg::INTERCEPT_FRAC_WIDTH;

  // Chord slope, truncated toward zero so it stays on the high side
  function automatic softermax_recip_pkg::slope_t chord_slope(input int seg);
    real x1;
    real x2;
    real m;
    x1 = 1.0 + real'(seg) / real'(ENTRIES);
    x2 = 1.0 + real'(seg + 1) / real'(ENTRIES);
    m  = (1.0 / x2 - 1.0 / x1) / (x2 - x1);
    return softermax_recip_pkg::slope_t'($rtoi(m * real'(SLOPE_SCALE)));
  endfunction

  // Intercept through the left end point using the quantized slope
  function automatic softermax_recip_pkg::intercept_t chord_intercept(input int seg);
    real x1;
    real m_q;
    real c;
    x1  = 1.0 + real'(seg) / real'(ENTRIES);
    m_q = real'($signed(chord_slope(seg))) / real'(SLOPE_SCALE);
    c   = 1.0 / x1 - m_q * x1;
    return softermax_recip_pkg::intercept_t'($rtoi(c * real'(INTERCEPT_SCALE)));
  endfunction

  softermax_recip_pkg::slope_t     slope_lut     [ENTRIES];
  softermax_recip_pkg::intercept_t intercept_lut [ENTRIES];

  for (genvar i = 0; i < ENTRIES; i++) begin : g_seg
    localparam softermax_recip_pkg::slope_t     SLOPE     = chord_slope(i);
    localparam softermax_recip_pkg::intercept_t INTERCEPT = chord_intercept(i);
    assign slope_lut[i]     = SLOPE;
    assign intercept_lut[i] = INTERCEPT;
  end

  assign slope     = slope_lut[seg_slope];
  assign intercept = intercept_lut[seg_intercept];

endmodule

`default_nettype wire

//--- rtl/skid_buffer.sv
// Two-entry register slice for a valid/ready stream.
// Passes one item per cycle with one cycle of latency. The ready toward
// the source comes straight from a flop, and a skid entry catches the item
// that arrives in the cycle after the sink drops ready.

`timescale 1ns/100ps
`default_nettype none

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] main_data;
  logic [DATA_WIDTH-1:0] skid_data;
  logic                  main_valid;
  logic                  skid_valid;
  logic                  main_load;

  // Main entry advances when empty or being drained
  assign main_load = !main_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // Skid entry drains first, source is stalled while it is full
      main_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : data_in;
    end
    if (in_ready) begin
      skid_data <= data_in;
    end
  end

  // Low only with both entries full
  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign data_out  = main_data;

endmodule

`default_nettype wire

//--- rtl/softermax_lpw_reciprocal.sv
// Streaming 1/x for unsigned Q4.4 samples, result in unsigned Q3.5.
// Input is normalized into [1, 2), evaluated on a piecewise linear chord
// table and shifted back. Zero and overflow give all ones. Five skid
// buffers give five cycles of latency at one item per cycle.

`timescale 1ns/100ps
`default_nettype none

module softermax_lpw_reciprocal #(
  parameter  int ENTRIES   = 8,
  localparam int SEG_WIDTH = $clog2(ENTRIES)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  softermax_recip_pkg::in_data_t  in_data,
  input  logic                           in_valid,
  output logic                           in_ready,
  output softermax_recip_pkg::out_data_t out_data,
  output logic                           out_valid,
  input  logic                           out_ready
);

  localparam int MSB_W    = softermax_recip_pkg::MSB_WIDTH;
  localparam int RANGE_DW = softermax_recip_pkg::REDUCED_WIDTH + MSB_W + 1;
  localparam int MULT_DW  = softermax_recip_pkg::MULT_WIDTH + SEG_WIDTH + MSB_W + 1;
  localparam int LPW_DW   = softermax_recip_pkg::LPW_WIDTH
                            + softermax_recip_pkg::SHIFT_WIDTH + 1;
  localparam int RECIP_DW = softermax_recip_pkg::RECIP_WIDTH + 1;
  localparam int SEG_MSB  = softermax_recip_pkg::REDUCED_FRAC_WIDTH - 1;

  softermax_recip_pkg::reduced_t   range_d;
  softermax_recip_pkg::msb_idx_t   msb_d;
  logic                            zero_d;

  softermax_recip_pkg::reduced_t   range_q;
  softermax_recip_pkg::msb_idx_t   range_msb;
  logic                            range_zero;
  logic                            range_valid;
  logic                            range_ready;

  logic [SEG_WIDTH-1:0]            seg_d;
  logic [SEG_WIDTH-1:0]            seg_q;
  softermax_recip_pkg::slope_t     slope;
  softermax_recip_pkg::mult_t      mult_d;
  softermax_recip_pkg::mult_t      mult_q;
  softermax_recip_pkg::msb_idx_t   mult_msb;
  logic                            mult_zero;
  logic                            mult_valid;
  logic                            mult_ready;

  softermax_recip_pkg::intercept_t intercept;
  softermax_recip_pkg::lpw_t       lpw_d;
  softermax_recip_pkg::lpw_t       lpw_q;
  softermax_recip_pkg::shift_t     shift_d;
  softermax_recip_pkg::shift_t     shift_q;
  logic                            lpw_zero;
  logic                            lpw_valid;
  logic                            lpw_ready;

  logic signed [softermax_recip_pkg::RECIP_WIDTH-1:0] lpw_ext;
  softermax_recip_pkg::recip_t     recip_d;
  softermax_recip_pkg::recip_t     recip_q;
  logic                            recip_zero;
  logic                            recip_valid;
  logic                            recip_ready;

  softermax_recip_pkg::out_data_t  cast_data;
  softermax_recip_pkg::out_data_t  out_d;

  // Stage 1: normalize into Q1.7
  fixed_range_reduction u_range (
    .data_in   (in_data),
    .data_out  (range_d),
    .msb_index (msb_d),
    .not_found (zero_d)
  );

  skid_buffer #(.DATA_WIDTH(RANGE_DW)) u_range_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   ({range_d, msb_d, zero_d}),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .data_out  ({range_q, range_msb, range_zero}),
    .out_valid (range_valid),
    .out_ready (range_ready)
  );

  // Top fraction bits pick the segment
  assign seg_d = range_q[SEG_MSB -: SEG_WIDTH];

  lpw_coeff_rom #(.ENTRIES(ENTRIES)) u_coeff (
    .seg_slope     (seg_d),
    .slope         (slope),
    .seg_intercept (seg_q),
    .intercept     (intercept)
  );

  // Stage 2: m * x, two's complement product keeps the low bits exact
  assign mult_d = softermax_recip_pkg::mult_t'(range_q)
                  * softermax_recip_pkg::mult_t'($signed(slope));

  skid_buffer #(.DATA_WIDTH(MULT_DW)) u_mult_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   ({mult_d, seg_d, range_msb, range_zero}),
    .in_valid  (range_valid),
    .in_ready  (range_ready),
    .data_out  ({mult_q, seg_q, mult_msb, mult_zero}),
    .out_valid (mult_valid),
    .out_ready (mult_ready)
  );

  // Stage 3: m * x + c, and the scale back as a signed shift
  assign lpw_d   = softermax_recip_pkg::lpw_t'($signed(mult_q))
                   + softermax_recip_pkg::lpw_t'(intercept);
  assign shift_d = softermax_recip_pkg::shift_t'(softermax_recip_pkg::IN_FRAC_WIDTH)
                   - softermax_recip_pkg::shift_t'(mult_msb);

  skid_buffer #(.DATA_WIDTH(LPW_DW)) u_lpw_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   ({lpw_d, shift_d, mult_zero}),
    .in_valid  (mult_valid),
    .in_ready  (mult_ready),
    .data_out  ({lpw_q, shift_q, lpw_zero}),
    .out_valid (lpw_valid),
    .out_ready (lpw_ready)
  );

  // Stage 4: small inputs shift left, large ones right
  assign lpw_ext = softermax_recip_pkg::recip_t'($signed(lpw_q));

  always_comb begin
    if (shift_q >= 0) begin
      recip_d = lpw_ext <<< shift_q;
    end else begin
      recip_d = lpw_ext >>> (-shift_q);
    end
  end

  skid_buffer #(.DATA_WIDTH(RECIP_DW)) u_recip_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   ({recip_d, lpw_zero}),
    .in_valid  (lpw_valid),
    .in_ready  (lpw_ready),
    .data_out  ({recip_q, recip_zero}),
    .out_valid (recip_valid),
    .out_ready (recip_ready)
  );

  // Stage 5: floor to Q3.5, 1/0 forced to the largest code
  fixed_unsigned_cast u_cast (
    .data_in  (recip_q),
    .data_out (cast_data)
  );

  assign out_d = recip_zero ? '1 : cast_data;

  skid_buffer #(.DATA_WIDTH(softermax_recip_pkg::OUT_WIDTH)) u_out_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (out_d),
    .in_valid  (recip_valid),
    .in_ready  (recip_ready),
    .data_out  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

//--- rtl/softermax_recip_pkg.sv
// Fixed-point formats shared by the LPW reciprocal pipeline.
// Input is unsigned Q4.4, output is unsigned Q3.5. Intermediate widths
// follow from the normalized Q1.7 value and the Q1.8 slope.

`default_nettype none

package softermax_recip_pkg;

  // External formats
  localparam int IN_WIDTH       = 8;
  localparam int IN_FRAC_WIDTH  = 4;
  localparam int OUT_WIDTH      = 8;
  localparam int OUT_FRAC_WIDTH = 5;

  // Normalized value x in [1, 2), Q1.7
  localparam int REDUCED_WIDTH      = IN_WIDTH;
  localparam int REDUCED_FRAC_WIDTH = IN_WIDTH - 1;

  localparam int MSB_WIDTH   = $clog2(IN_WIDTH);
  localparam int SHIFT_WIDTH = MSB_WIDTH + 1;

  // Slope m is negative, one sign bit above the fraction
  localparam int SLOPE_FRAC_WIDTH = 8;
  localparam int SLOPE_WIDTH      = SLOPE_FRAC_WIDTH + 1;

  localparam int MULT_WIDTH      = REDUCED_WIDTH + SLOPE_WIDTH;
  localparam int MULT_FRAC_WIDTH = REDUCED_FRAC_WIDTH + SLOPE_FRAC_WIDTH;

  // Intercept lines up with the product, c stays below 2
  localparam int INTERCEPT_FRAC_WIDTH = MULT_FRAC_WIDTH;
  localparam int INTERCEPT_WIDTH      = INTERCEPT_FRAC_WIDTH + 2;

  localparam int LPW_WIDTH = MULT_WIDTH + 1;

  // Room for a left shift of up to IN_FRAC_WIDTH
  localparam int RECIP_FRAC_WIDTH = MULT_FRAC_WIDTH;
  localparam int RECIP_WIDTH      = LPW_WIDTH + IN_FRAC_WIDTH;

  // Skid-buffer stages between input and output
  localparam int PIPE_LATENCY = 5;

  typedef logic [IN_WIDTH-1:0]               in_data_t;
  typedef logic [OUT_WIDTH-1:0]              out_data_t;
  typedef logic [REDUCED_WIDTH-1:0]          reduced_t;
  typedef logic [MSB_WIDTH-1:0]              msb_idx_t;
  typedef logic signed [SHIFT_WIDTH-1:0]     shift_t;
  typedef logic [SLOPE_WIDTH-1:0]            slope_t;
  typedef logic [MULT_WIDTH-1:0]             mult_t;
  typedef logic [INTERCEPT_WIDTH-1:0]        intercept_t;
  typedef logic [LPW_WIDTH-1:0]              lpw_t;
  typedef logic [RECIP_WIDTH-1:0]            recip_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the reciprocal pipeline testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_softermax_lpw_reciprocal \
  -f softermax_lpw_reciprocal.f \
  -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
echo "Simulation finished without failure"

//--- softermax_lpw_reciprocal.f
rtl/softermax_recip_pkg.sv
rtl/skid_buffer.sv
rtl/fixed_range_reduction.sv
rtl/lpw_coeff_rom.sv
rtl/fixed_unsigned_cast.sv
rtl/softermax_lpw_reciprocal.sv
tb/tb_softermax_lpw_reciprocal.sv

//--- tb/tb_softermax_lpw_reciprocal.sv
// Self-checking testbench for the streaming LPW reciprocal pipeline.
// Accepted inputs go into a scoreboard queue; every output is checked
// against floor(512 / code) with saturation, allowing one LSB above.
// Covers reset, zero input, a full sweep, latency and back-pressure.

`timescale 1ns/100ps
`default_nettype none

module tb_softermax_lpw_reciprocal;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int RANDOM_ITEMS    = 300;
  localparam int BURST_ITEMS     = 16;
  localparam int TRANSFERS       = 3 + 256 + BURST_ITEMS + RANDOM_ITEMS;
  localparam int WATCHDOG_CYCLES = TRANSFERS * 20 + 500;
  localparam int DRAIN_LIMIT     = 2000;

  logic                           clk;
  logic                           rst_n;
  softermax_recip_pkg::in_data_t  in_data;
  logic                           in_valid;
  logic                           in_ready;
  softermax_recip_pkg::out_data_t out_data;
  logic                           out_valid;
  logic                           out_ready;

  softermax_recip_pkg::in_data_t  expected_q [$];
  softermax_recip_pkg::in_data_t  exp_code;
  int seed = 15;
  int ready_seed = 16;
  int errors = 0;
  int test_errors_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle = 0;
  int ideal;
  int accept_cycle;
  int first_out_cycle;
  int run_len;
  int run_max;
  logic lat_armed = 1'b0;
  logic ready_random = 1'b0;

  softermax_lpw_reciprocal #(.ENTRIES(8)) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // Floor of 512 / code saturated to the largest Q3.5 code
  function automatic int ideal_recip(input int code);
    int q;
    if (code == 0) begin
      return 255;
    end
    q = 512 / code;
    return (q > 255) ? 255 : q;
  endfunction

  function automatic bit is_pow2(input int code);
    return (code != 0) && ((code & (code - 1)) == 0);
  endfunction

  // Sink ready is random only during the back-pressure test
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_ready = ready_random ? (($random(ready_seed) % 2) != 0) : 1'b1;
    end
  end

  // Scoreboard and per-output checks on the pre-edge values
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_valid && in_ready) begin
        expected_q.push_back(in_data);
        if (lat_armed && accept_cycle < 0) begin
          accept_cycle = cycle;
        end
      end
      if (lat_armed && out_valid && first_out_cycle < 0) begin
        first_out_cycle = cycle;
      end
      run_len = out_valid ? run_len + 1 : 0;
      if (run_len > run_max) begin
        run_max = run_len;
      end
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          $display("Output %0d appeared at %0t with no input waiting for it", out_data, $time);
          errors++;
        end else begin
          exp_code = expected_q.pop_front();
          ideal = ideal_recip(int'(exp_code));
          out_range: assert (int'(out_data) >= ideal && int'(out_data) <= ideal + 1) else begin
            $display("ERROR %0t: code %0d gave %0d, expected %0d to %0d",
                     $time, exp_code, out_data, ideal, ideal + 1);
            errors++;
          end
          if (is_pow2(int'(exp_code))) begin
            out_exact: assert (int'(out_data) == ideal) else begin
              $display("ERROR %0t: power of two %0d gave %0d, expected %0d",
                       $time, exp_code, out_data, ideal);
              errors++;
            end
          end
        end
      end
    end
    cycle++;
  end

  // Stalled output must keep its data
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
  else begin
    $display("ERROR %0t: output changed or dropped while stalled", $time);
    errors++;
  end

  // Called 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic send_item(input softermax_recip_pkg::in_data_t code);
    in_data  = code;
    in_valid = 1'b1;
    // Registered in_ready holds its value until the next edge
    while (!in_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expected_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    repeat (2) @(posedge clk);
    #1;
    if (expected_q.size() != 0) begin
      $display("Outputs missing: %0d items never left the pipeline", expected_q.size());
      errors++;
    end
  endtask

  task automatic start_test();
    test_errors_start = errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - test_errors_start;
    if (n == 0) begin
      tests_passed++;
      $display("[%0t] %s: PASS", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAIL with %0d errors", $time, name, n);
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    in_data  = '0;
    in_valid = 1'b0;

    start_test();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_idle: assert (!out_valid && in_ready) else begin
      $display("ERROR %0t: out_valid or in_ready wrong during reset", $time);
      errors++;
    end
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    reset_after: assert (!out_valid && in_ready) else begin
      $display("ERROR %0t: out_valid or in_ready wrong after reset", $time);
      errors++;
    end
    end_test("reset state");

    start_test();
    for (int c = 0; c < 3; c++) begin
      send_item(softermax_recip_pkg::in_data_t'(c));
    end
    wait_drain();
    end_test("zero and saturating inputs");

    start_test();
    for (int c = 0; c < 256; c++) begin
      send_item(softermax_recip_pkg::in_data_t'(c));
    end
    wait_drain();
    end_test("accuracy sweep");

    start_test();
    accept_cycle    = -1;
    first_out_cycle = -1;
    run_max         = 0;
    lat_armed       = 1'b1;
    for (int i = 0; i < BURST_ITEMS; i++) begin
      send_item(softermax_recip_pkg::in_data_t'(16 + i));
    end
    wait_drain();
    lat_armed = 1'b0;
    latency: assert (first_out_cycle - accept_cycle == softermax_recip_pkg::PIPE_LATENCY)
    else begin
      $display("ERROR %0t: latency %0d cycles, expected %0d", $time,
               first_out_cycle - accept_cycle, softermax_recip_pkg::PIPE_LATENCY);
      errors++;
    end
    throughput: assert (run_max >= BURST_ITEMS) else begin
      $display("ERROR %0t: out_valid ran %0d cycles, expected %0d", $time,
               run_max, BURST_ITEMS);
      errors++;
    end
    end_test("latency and throughput");

    start_test();
    ready_random = 1'b1;
    for (int i = 0; i < RANDOM_ITEMS; i++) begin
      while (($random(seed) & 3) == 0) begin
        @(posedge clk);
        #1;
      end
      send_item(softermax_recip_pkg::in_data_t'($random(seed)));
    end
    ready_random = 1'b0;
    wait_drain();
    end_test("back-pressure");

    $display("Summary: %0d tests passed, %0d failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
